/* rv_pipe.f */
logic/rv_pipe_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_hazard.sv
logic/rv_execute.sv
logic/rv_mem_wb.sv
logic/rv_pipe.sv
tests/tb_memories.sv
tests/tb_rv_pipe.sv

/* Bender.yml */
package:
  name: rv_pipe

sources:
  - logic/rv_pipe_pkg.sv
  - logic/rv_fetch.sv
  - logic/rv_decode.sv
  - logic/rv_hazard.sv
  - logic/rv_execute.sv
  - logic/rv_mem_wb.sv
  - logic/rv_pipe.sv
  - target: test
    files:
      - tests/tb_memories.sv
      - tests/tb_rv_pipe.sv

/* tests/tb_rv_pipe.sv */
// testbench top: clock, reset, watchdog, instruction model, assertions and summary
`timescale 1ns/1ps

module tb_rv_pipe
	import rv_pipe_pkg::*;
;

	localparam int prog_len     = 37;
	localparam int stall_factor = 8;
	localparam int limit_cycles = 16 + (prog_len * 3 + 40) * stall_factor;
	localparam logic [29:0] poison_word = 30'h0ff;

	logic clk;
	logic rst_n;
	logic [6:0] imem_addr;
	logic [31:0] imem_rdata;
	logic imem_stall;
	logic dmem_read;
	logic dmem_write;
	logic [29:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [31:0] dmem_rdata;
	logic dmem_stall;

	int cycle;
	int errors;
	int tests_done;
	int seen;
	int total;
	int left_per_test [1:4];
	logic [2:0]  exp_test [$];
	logic [29:0] exp_addr [$];
	logic [31:0] exp_data [$];
	string test_names [1:4] = '{"alu and forwarding", "load-use", "branches", "jal link"};

	rv_pipe #(.pc_width(9)) dut0 (.*);

	tb_memories #(.stall_pct(25), .seed(32'h596b)) mem0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	// ------------------------------------------------------------------------
	// instruction-level model of the program, gives the store list
	// ------------------------------------------------------------------------
	task automatic build_expected();
		logic [31:0] x [0:31];
		logic [31:0] dmem [logic [29:0]];
		logic [31:0] ins;
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] imm;
		logic [29:0] wa;
		for (int i = 0; i < 32; i++)
			x[i] = '0;
		pc = 0;
		for (int step = 0; step < 200; step++) begin
			ins = mem0.rom[pc[8:2]];
			if (ins == 32'h0000006f)
				break;
			a = x[ins[19:15]];
			b = x[ins[24:20]];
			imm = {{20{ins[31]}}, ins[31:20]};
			res = 'x;
			if (ins[6:0] == op_rtype || ins[6:0] == op_itype) begin
				if (ins[6:0] == op_itype)
					b = imm;
				case (ins[14:12])
					3'b010: res = {31'd0, $signed(a) < $signed(b)};
					3'b110: res = a | b;
					3'b111: res = a & b;
					default: res = (ins[6:0] == op_rtype && ins[30]) ? a - b : a + b;
				endcase
			end else if (ins[6:0] == op_load) begin
				wa = (a + imm) >> 2;
				res = dmem.exists(wa) ? dmem[wa] : mem0.ram[wa[7:0]];
			end else if (ins[6:0] == op_store) begin
				wa = (a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2;
				dmem[wa] = b;
				exp_test.push_back(wa[6:4]);
				exp_addr.push_back(wa);
				exp_data.push_back(b);
				left_per_test[wa[6:4]]++;
			end
			if (ins[6:0] == op_jal) begin
				res = pc + 4;
				pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end else if (ins[6:0] == op_branch && ((a == b) != ins[12])) begin
				pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			end else begin
				pc = pc + 4;
			end
			if (!(ins[6:0] inside {op_store, op_branch}) && ins[11:7] != 0)
				x[ins[11:7]] = res;
		end
		total = exp_addr.size();
	endtask

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	a_reset_state: assert property (@(posedge clk) (cycle >= 1 && cycle <= 16) |->
			(!dmem_read && !dmem_write && imem_addr == 0))
		else begin
			errors++;
			$display("Fail at %0t: port not idle or address not 0 around reset", $time);
		end

	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
			(dmem_stall && dmem_write) |=> (dmem_write && $stable(dmem_addr) &&
			$stable(dmem_wdata)))
		else begin
			errors++;
			$display("Fail at %0t: store request changed while dmem_stall was high", $time);
		end

	a_no_poison: assert property (@(posedge clk) disable iff (!rst_n)
			!(dmem_write && dmem_addr == poison_word))
		else begin
			errors++;
			$display("Fail at %0t: store to the poison address", $time);
		end

	// a store counts once the whole pipe moves past it
	always @(posedge clk) begin
		if (rst_n && dmem_write && !dmem_stall && !imem_stall) begin
			if (exp_addr.size() == 0) begin
				errors++;
				$display("extra store to word %h after the sequence ended", dmem_addr);
			end else begin
				assert (dmem_addr == exp_addr[0] && dmem_wdata == exp_data[0])
				else begin
					errors++;
					$display("Fail at %0t: store %0d got %h <= %h, expected %h <= %h", $time,
						seen, dmem_addr, dmem_wdata, exp_addr[0], exp_data[0]);
				end
				left_per_test[exp_test[0]]--;
				if (left_per_test[exp_test[0]] == 0) begin
					tests_done++;
					$display("test %s: done, errors so far %0d", test_names[exp_test[0]], errors);
				end
				void'(exp_test.pop_front());
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				seen++;
			end
		end
	end

	initial begin
		#(limit_cycles * 100);
		$display("timeout: the store sequence did not complete in %0d cycles", limit_cycles);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int quiet;
		rst_n = 1'b0;
		cycle = 0;
		errors = 0;
		tests_done = 0;
		seen = 0;
		for (int t = 1; t <= 4; t++)
			left_per_test[t] = 0;
		@(posedge clk);
		build_expected();
		repeat (15) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		tests_done++;
		$display("test reset state: done, errors so far %0d", errors);
		wait (seen == total);
		// let the pipe run on to catch a repeated or stray store
		quiet = 0;
		while (quiet < 20) begin
			@(posedge clk);
			if (!imem_stall && !dmem_stall)
				quiet++;
		end
		tests_done++;
		$display("test back-pressure: %0d of %0d stores, errors so far %0d", seen, total,
			errors);
		$display("tests run: %0d, checks failed: %0d", tests_done, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* tests/tb_memories.sv */
// instruction ROM with the test program and data RAM, both with random stall injection
`timescale 1ns/1ps

module tb_memories
	import rv_pipe_pkg::*;
#(
	parameter int stall_pct = 25,
	parameter logic [31:0] seed = 32'h596b
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [6:0]  imem_addr,
	output logic [31:0] imem_rdata,
	output logic        imem_stall,
	input  logic        dmem_read,
	input  logic        dmem_write,
	input  logic [29:0] dmem_addr,
	input  logic [31:0] dmem_wdata,
	output logic [31:0] dmem_rdata,
	output logic        dmem_stall
);

	logic [31:0] rom [0:127];
	logic [31:0] ram [0:255];

	function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_rtype};
	endfunction

	function automatic logic [31:0] i_op(input logic [6:0] op, input logic [11:0] imm,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_op(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_op(input logic [2:0] f3, input logic [12:0] off,
			input logic [4:0] rs1, input logic [4:0] rs2);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic logic [31:0] j_op(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	initial begin
		// unused words spin on jal x0, 0
		for (int i = 0; i < 128; i++)
			rom[i] = j_op(5'd0, 21'd0);
		for (int i = 0; i < 256; i++)
			ram[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
		// ------------------------------------------------------------------------
		// ALU chain and forwarding, stores at 0x40
		// ------------------------------------------------------------------------
		rom[0]  = i_op(op_itype, 12'd5, 5'd0, 3'b000, 5'd1);
		rom[1]  = i_op(op_itype, 12'd7, 5'd1, 3'b000, 5'd2);
		rom[2]  = r_op(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
		rom[3]  = r_op(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
		rom[4]  = r_op(7'h00, 5'd3, 5'd4, 3'b111, 5'd5);
		rom[5]  = r_op(7'h00, 5'd3, 5'd5, 3'b110, 5'd6);
		rom[6]  = r_op(7'h00, 5'd2, 5'd1, 3'b010, 5'd7);
		rom[7]  = i_op(op_itype, -12'sd3, 5'd4, 3'b010, 5'd8);
		rom[8]  = i_op(op_itype, 12'h01f, 5'd3, 3'b111, 5'd9);
		rom[9]  = i_op(op_itype, 12'h100, 5'd9, 3'b110, 5'd10);
		rom[10] = i_op(op_itype, 12'h040, 5'd0, 3'b000, 5'd11);
		rom[11] = s_op(12'd0, 5'd3, 5'd11);
		rom[12] = s_op(12'd4, 5'd4, 5'd11);
		rom[13] = s_op(12'd8, 5'd6, 5'd11);
		rom[14] = s_op(12'd12, 5'd7, 5'd11);
		rom[15] = s_op(12'd16, 5'd10, 5'd11);
		// load-use, stores at 0x80
		rom[16] = i_op(op_itype, 12'h080, 5'd0, 3'b000, 5'd12);
		rom[17] = i_op(op_load, 12'd0, 5'd11, 3'b010, 5'd13);
		rom[18] = r_op(7'h00, 5'd1, 5'd13, 3'b000, 5'd14);
		rom[19] = s_op(12'd0, 5'd14, 5'd12);
		rom[20] = i_op(op_load, 12'd4, 5'd11, 3'b010, 5'd15);
		rom[21] = s_op(12'd4, 5'd15, 5'd12);
		// branches, poison word at 0x3fc
		rom[22] = i_op(op_itype, 12'h0c0, 5'd0, 3'b000, 5'd16);
		rom[23] = i_op(op_itype, 12'h3fc, 5'd0, 3'b000, 5'd20);
		rom[24] = b_op(3'b000, 13'd8, 5'd1, 5'd1);
		rom[25] = s_op(12'd0, 5'd1, 5'd20);
		rom[26] = b_op(3'b001, 13'd8, 5'd1, 5'd2);
		rom[27] = s_op(12'd0, 5'd2, 5'd20);
		rom[28] = b_op(3'b000, 13'd8, 5'd1, 5'd2);
		rom[29] = s_op(12'd0, 5'd1, 5'd16);
		rom[30] = b_op(3'b001, 13'd8, 5'd1, 5'd1);
		rom[31] = s_op(12'd4, 5'd2, 5'd16);
		// jal and link, store at 0x100
		rom[32] = i_op(op_itype, 12'h100, 5'd0, 3'b000, 5'd17);
		rom[33] = j_op(5'd18, 21'd8);
		rom[34] = s_op(12'd0, 5'd1, 5'd20);
		rom[35] = s_op(12'd0, 5'd18, 5'd17);
		rom[36] = j_op(5'd0, 21'd0);
	end

	assign imem_rdata = rom[imem_addr];
	// read data only while a load is presented
	assign dmem_rdata = dmem_read ? ram[dmem_addr[7:0]] : 32'h0;

	always @(posedge clk) begin
		if (dmem_write && !dmem_stall)
			ram[dmem_addr[7:0]] <= dmem_wdata;
	end

	// one process draws every random stall
	initial begin
		void'($urandom(seed));
		imem_stall = 1'b0;
		dmem_stall = 1'b0;
		forever begin
			@(posedge clk);
			imem_stall <= rst_n && ($urandom % 100 < stall_pct);
			dmem_stall <= rst_n && ($urandom % 100 < stall_pct);
		end
	end

endmodule

/* logic/rv_pipe.sv */
// top level of the five-stage core, stage wiring and global stall
`timescale 1ns/1ps

module rv_pipe
	import rv_pipe_pkg::*;
#(
	parameter int pc_width = 9
) (
	input  logic                clk,
	input  logic                rst_n,
	output logic [pc_width-3:0] imem_addr,
	input  logic [xlen-1:0]     imem_rdata,
	input  logic                imem_stall,
	output logic                dmem_read,
	output logic                dmem_write,
	output logic [xlen-3:0]     dmem_addr,
	output logic [xlen-1:0]     dmem_wdata,
	input  logic [xlen-1:0]     dmem_rdata,
	input  logic                dmem_stall
);

	logic stall;
	// hazard
	logic bubble;
	logic pc_hold;
	logic flush_if;
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;
	// fetch and decode
	instr_t id_instr;
	logic [pc_width-1:0] id_pc;
	logic jump_taken;
	logic [pc_width-1:0] jump_target;
	logic [reg_addr_width-1:0] rs1;
	logic [reg_addr_width-1:0] rs2;
	// ID/EX
	alu_op_t ex_alu_op;
	logic ex_alusrc;
	logic ex_memread;
	logic ex_memwrite;
	logic ex_memtoreg;
	logic ex_regwrite;
	logic ex_jal;
	logic ex_branch;
	logic ex_bne;
	logic [xlen-1:0] ex_rs1_data;
	logic [xlen-1:0] ex_rs2_data;
	logic [xlen-1:0] ex_imm;
	logic [reg_addr_width-1:0] ex_rd;
	logic [pc_width-1:0] ex_pc_plus4;
	logic [pc_width-1:0] ex_branch_target;
	logic [xlen-1:0] ex_result;
	logic branch_taken;
	logic [pc_width-1:0] branch_target;
	// EX/MEM
	logic mem_memread;
	logic mem_memwrite;
	logic mem_memtoreg;
	logic mem_regwrite;
	logic mem_link;
	logic [xlen-1:0] mem_alu_result;
	logic [xlen-1:0] mem_store_data;
	logic [reg_addr_width-1:0] mem_rd;
	logic [xlen-1:0] mem_pc_plus4;
	logic [xlen-1:0] mem_fwd_data;
	// MEM/WB
	logic wb_regwrite;
	logic [reg_addr_width-1:0] wb_rd;
	logic [xlen-1:0] wb_data;

	// either port waiting freezes the whole pipe
	assign stall = imem_stall | dmem_stall;

	rv_fetch #(.pc_width(pc_width)) fetch0 (
		.clk, .rst_n, .stall, .pc_hold, .flush_if,
		.jump_taken, .jump_target, .branch_taken, .branch_target,
		.imem_addr, .imem_rdata, .id_instr, .id_pc
	);

	rv_decode #(.pc_width(pc_width)) decode0 (
		.clk, .rst_n, .stall, .bubble, .fwd_a, .fwd_b, .id_instr, .id_pc,
		.wb_regwrite, .wb_rd, .wb_data, .mem_fwd_data, .ex_result,
		.jump_taken, .jump_target, .rs1, .rs2,
		.ex_alu_op, .ex_alusrc, .ex_memread, .ex_memwrite, .ex_memtoreg, .ex_regwrite,
		.ex_jal, .ex_branch, .ex_bne, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_rd,
		.ex_pc_plus4, .ex_branch_target
	);

	rv_hazard hazard0 (
		.rs1, .rs2, .id_opcode(id_instr.rfmt.opcode),
		.ex_rd, .ex_memread, .ex_regwrite, .mem_rd, .mem_regwrite, .wb_rd, .wb_regwrite,
		.jump_taken, .branch_taken, .bubble, .pc_hold, .flush_if, .fwd_a, .fwd_b
	);

	rv_execute #(.pc_width(pc_width)) execute0 (
		.clk, .rst_n, .stall,
		.ex_alu_op, .ex_alusrc, .ex_memread, .ex_memwrite, .ex_memtoreg, .ex_regwrite,
		.ex_jal, .ex_branch, .ex_bne, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_rd,
		.ex_pc_plus4, .ex_branch_target, .ex_result, .branch_taken, .branch_target,
		.mem_memread, .mem_memwrite, .mem_memtoreg, .mem_regwrite, .mem_link,
		.mem_alu_result, .mem_store_data, .mem_rd, .mem_pc_plus4
	);

	rv_mem_wb mem_wb0 (
		.clk, .rst_n, .stall,
		.mem_memread, .mem_memwrite, .mem_memtoreg, .mem_regwrite, .mem_link,
		.mem_alu_result, .mem_store_data, .mem_rd, .mem_pc_plus4, .dmem_rdata,
		.dmem_read, .dmem_write, .dmem_addr, .dmem_wdata, .mem_fwd_data,
		.wb_regwrite, .wb_rd, .wb_data
	);

endmodule

/* logic/rv_mem_wb.sv */
// data port drive, MEM/WB register and write-back select
`timescale 1ns/1ps

module rv_mem_wb
	import rv_pipe_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      stall,
	input  logic                      mem_memread,
	input  logic                      mem_memwrite,
	input  logic                      mem_memtoreg,
	input  logic                      mem_regwrite,
	input  logic                      mem_link,
	input  logic [xlen-1:0]           mem_alu_result,
	input  logic [xlen-1:0]           mem_store_data,
	input  logic [reg_addr_width-1:0] mem_rd,
	input  logic [xlen-1:0]           mem_pc_plus4,
	input  logic [xlen-1:0]           dmem_rdata,
	output logic                      dmem_read,
	output logic                      dmem_write,
	output logic [xlen-3:0]           dmem_addr,
	output logic [xlen-1:0]           dmem_wdata,
	output logic [xlen-1:0]           mem_fwd_data,
	output logic                      wb_regwrite,
	output logic [reg_addr_width-1:0] wb_rd,
	output logic [xlen-1:0]           wb_data
);

	logic wb_link;
	logic [xlen-1:0] wb_value;
	logic [xlen-1:0] wb_pc_plus4;

	// request straight from EX/MEM, stable while frozen
	assign dmem_read  = mem_memread;
	assign dmem_write = mem_memwrite;
	assign dmem_addr  = mem_alu_result[xlen-1:2];
	assign dmem_wdata = mem_store_data;

	// load data arrives in the same cycle
	assign mem_fwd_data = mem_memread ? dmem_rdata : (mem_link ? mem_pc_plus4 : mem_alu_result);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_regwrite <= 1'b0;
			wb_link     <= 1'b0;
		end else if (!stall) begin
			wb_regwrite <= mem_regwrite;
			wb_link     <= mem_link;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			wb_rd       <= mem_rd;
			wb_value    <= mem_memtoreg ? dmem_rdata : mem_alu_result;
			wb_pc_plus4 <= mem_pc_plus4;
		end
	end

	assign wb_data = wb_link ? wb_pc_plus4 : wb_value;

endmodule

/* logic/rv_execute.sv */
// ALU, operand mux, branch decision and EX/MEM register
`timescale 1ns/1ps

module rv_execute
	import rv_pipe_pkg::*;
#(
	parameter int pc_width = 9
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      stall,
	input  alu_op_t                   ex_alu_op,
	input  logic                      ex_alusrc,
	input  logic                      ex_memread,
	input  logic                      ex_memwrite,
	input  logic                      ex_memtoreg,
	input  logic                      ex_regwrite,
	input  logic                      ex_jal,
	input  logic                      ex_branch,
	input  logic                      ex_bne,
	input  logic [xlen-1:0]           ex_rs1_data,
	input  logic [xlen-1:0]           ex_rs2_data,
	input  logic [xlen-1:0]           ex_imm,
	input  logic [reg_addr_width-1:0] ex_rd,
	input  logic [pc_width-1:0]       ex_pc_plus4,
	input  logic [pc_width-1:0]       ex_branch_target,
	output logic [xlen-1:0]           ex_result,
	output logic                      branch_taken,
	output logic [pc_width-1:0]       branch_target,
	output logic                      mem_memread,
	output logic                      mem_memwrite,
	output logic                      mem_memtoreg,
	output logic                      mem_regwrite,
	output logic                      mem_link,
	output logic [xlen-1:0]           mem_alu_result,
	output logic [xlen-1:0]           mem_store_data,
	output logic [reg_addr_width-1:0] mem_rd,
	output logic [xlen-1:0]           mem_pc_plus4
);

	logic [xlen-1:0] src_b;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] link_value;
	logic zero;

	assign src_b = ex_alusrc ? ex_imm : ex_rs2_data;

	always_comb begin
		case (ex_alu_op)
			alu_sub: alu_out = ex_rs1_data - src_b;
			alu_and: alu_out = ex_rs1_data & src_b;
			alu_or:  alu_out = ex_rs1_data | src_b;
			alu_slt: alu_out = xlen'($signed(ex_rs1_data) < $signed(src_b));
			default: alu_out = ex_rs1_data + src_b;
		endcase
	end

	assign zero = (alu_out == '0);

	// beq wants zero, bne wants not zero
	assign branch_taken  = ex_branch & (zero != ex_bne);
	assign branch_target = ex_branch_target;

	assign link_value = {{(xlen-pc_width){1'b0}}, ex_pc_plus4};
	// jal target may read the link register right away
	assign ex_result  = ex_jal ? link_value : alu_out;

	// --------------------------------------------------------------------------
	// EX/MEM register
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_memread  <= 1'b0;
			mem_memwrite <= 1'b0;
			mem_memtoreg <= 1'b0;
			mem_regwrite <= 1'b0;
			mem_link     <= 1'b0;
		end else if (!stall) begin
			mem_memread  <= ex_memread;
			mem_memwrite <= ex_memwrite;
			mem_memtoreg <= ex_memtoreg;
			mem_regwrite <= ex_regwrite;
			mem_link     <= ex_jal;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			mem_alu_result <= alu_out;
			mem_store_data <= ex_rs2_data;
			mem_rd         <= ex_rd;
			mem_pc_plus4   <= link_value;
		end
	end

endmodule

/* logic/rv_hazard.sv */
// load-use interlock, flush generation and forwarding source choice
`timescale 1ns/1ps

module rv_hazard
	import rv_pipe_pkg::*;
(
	input  logic [reg_addr_width-1:0] rs1,
	input  logic [reg_addr_width-1:0] rs2,
	input  logic [6:0]                id_opcode,
	input  logic [reg_addr_width-1:0] ex_rd,
	input  logic                      ex_memread,
	input  logic                      ex_regwrite,
	input  logic [reg_addr_width-1:0] mem_rd,
	input  logic                      mem_regwrite,
	input  logic [reg_addr_width-1:0] wb_rd,
	input  logic                      wb_regwrite,
	input  logic                      jump_taken,
	input  logic                      branch_taken,
	output logic                      bubble,
	output logic                      pc_hold,
	output logic                      flush_if,
	output logic [1:0]                fwd_a,
	output logic [1:0]                fwd_b
);

	logic uses_rs1;
	logic uses_rs2;
	logic load_use;

	// nearest producer wins, x0 is never forwarded
	function automatic logic [1:0] source(input logic [reg_addr_width-1:0] rs);
		if (rs == '0)
			return fwd_rf;
		if (ex_regwrite && ex_rd == rs)
			return fwd_ex;
		if (mem_regwrite && mem_rd == rs)
			return fwd_mem;
		if (wb_regwrite && wb_rd == rs)
			return fwd_wb;
		return fwd_rf;
	endfunction

	// rs fields of other formats hold immediate bits
	assign uses_rs1 = id_opcode inside {op_rtype, op_itype, op_load, op_store, op_branch};
	assign uses_rs2 = id_opcode inside {op_rtype, op_store, op_branch};

	assign load_use = ex_memread && ex_rd != '0 &&
			((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

	always_comb begin
		fwd_a = source(rs1);
		fwd_b = source(rs2);
	end

	assign pc_hold  = load_use;
	// a taken branch also kills the instruction sitting in decode
	assign bubble   = load_use | branch_taken;
	assign flush_if = jump_taken | branch_taken;

endmodule

/* logic/rv_decode.sv */
// register file, main and ALU-control decode, immediates, operand forwarding, ID/EX register
`timescale 1ns/1ps

module rv_decode
	import rv_pipe_pkg::*;
#(
	parameter int pc_width = 9
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      stall,
	input  logic                      bubble,
	input  logic [1:0]                fwd_a,
	input  logic [1:0]                fwd_b,
	input  instr_t                    id_instr,
	input  logic [pc_width-1:0]       id_pc,
	input  logic                      wb_regwrite,
	input  logic [reg_addr_width-1:0] wb_rd,
	input  logic [xlen-1:0]           wb_data,
	input  logic [xlen-1:0]           mem_fwd_data,
	input  logic [xlen-1:0]           ex_result,
	output logic                      jump_taken,
	output logic [pc_width-1:0]       jump_target,
	output logic [reg_addr_width-1:0] rs1,
	output logic [reg_addr_width-1:0] rs2,
	output alu_op_t                   ex_alu_op,
	output logic                      ex_alusrc,
	output logic                      ex_memread,
	output logic                      ex_memwrite,
	output logic                      ex_memtoreg,
	output logic                      ex_regwrite,
	output logic                      ex_jal,
	output logic                      ex_branch,
	output logic                      ex_bne,
	output logic [xlen-1:0]           ex_rs1_data,
	output logic [xlen-1:0]           ex_rs2_data,
	output logic [xlen-1:0]           ex_imm,
	output logic [reg_addr_width-1:0] ex_rd,
	output logic [pc_width-1:0]       ex_pc_plus4,
	output logic [pc_width-1:0]       ex_branch_target
);

	logic [xlen-1:0] regs [0:31];
	logic [xlen-1:0] rf_a;
	logic [xlen-1:0] rf_b;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_j;
	logic [pc_width-1:0] pc_plus_imm;
	alu_op_t alu_op;
	alu_op_t func_op;
	logic alusrc;
	logic memread;
	logic memwrite;
	logic memtoreg;
	logic regwrite;
	logic is_jal;
	logic is_branch;

	function automatic logic [xlen-1:0] pick(input logic [1:0] sel, input logic [xlen-1:0] rf_val,
			input logic [xlen-1:0] mem_val, input logic [xlen-1:0] ex_val,
			input logic [xlen-1:0] wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_ex:  return ex_val;
			// value being written at this edge
			fwd_wb:  return wb_val;
			default: return rf_val;
		endcase
	endfunction

	// --------------------------------------------------------------------------
	// register file, x0 reads zero
	// --------------------------------------------------------------------------
	assign rs1 = id_instr.rfmt.rs1;
	assign rs2 = id_instr.rfmt.rs2;
	assign rf_a = (rs1 == '0) ? '0 : regs[rs1];
	assign rf_b = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (!stall && wb_regwrite && wb_rd != '0)
			regs[wb_rd] <= wb_data;
	end

	// --------------------------------------------------------------------------
	// immediates and decode
	// --------------------------------------------------------------------------
	assign imm_i = {{(xlen-12){id_instr.rfmt.funct7[6]}}, id_instr.rfmt.funct7, id_instr.rfmt.rs2};
	assign imm_s = {{(xlen-12){id_instr.sfmt.imm_hi[6]}}, id_instr.sfmt.imm_hi,
			id_instr.sfmt.imm_lo};
	assign imm_b = {{(xlen-12){id_instr.sfmt.imm_hi[6]}}, id_instr.sfmt.imm_lo[0],
			id_instr.sfmt.imm_hi[5:0], id_instr.sfmt.imm_lo[4:1], 1'b0};
	// J format scattered over the register fields
	assign imm_j = {{(xlen-20){id_instr.rfmt.funct7[6]}}, id_instr.rfmt.rs1, id_instr.rfmt.funct3,
			id_instr.rfmt.rs2[0], id_instr.rfmt.funct7[5:0], id_instr.rfmt.rs2[4:1], 1'b0};

	always_comb begin
		case (id_instr.rfmt.funct3)
			3'b111:  func_op = alu_and;
			3'b110:  func_op = alu_or;
			3'b010:  func_op = alu_slt;
			default: begin
				if (id_instr.rfmt.opcode == op_rtype && id_instr.rfmt.funct7[5])
					func_op = alu_sub;
				else
					func_op = alu_add;
			end
		endcase
	end

	always_comb begin
		alu_op    = alu_add;
		alusrc    = 1'b0;
		memread   = 1'b0;
		memwrite  = 1'b0;
		memtoreg  = 1'b0;
		regwrite  = 1'b0;
		is_jal    = 1'b0;
		is_branch = 1'b0;
		imm       = imm_i;
		case (id_instr.rfmt.opcode)
			op_rtype: begin
				alu_op   = func_op;
				regwrite = 1'b1;
			end
			op_itype: begin
				alu_op   = func_op;
				alusrc   = 1'b1;
				regwrite = 1'b1;
			end
			op_load: begin
				alusrc   = 1'b1;
				memread  = 1'b1;
				memtoreg = 1'b1;
				regwrite = 1'b1;
			end
			op_store: begin
				alusrc   = 1'b1;
				memwrite = 1'b1;
				imm      = imm_s;
			end
			op_branch: begin
				alu_op    = alu_sub;
				is_branch = 1'b1;
				imm       = imm_b;
			end
			op_jal: begin
				is_jal   = 1'b1;
				regwrite = 1'b1;
				imm      = imm_j;
			end
			default: ;
		endcase
	end

	// shared adder for the jal target and the branch target
	assign pc_plus_imm = id_pc + imm[pc_width-1:0];
	assign jump_taken  = is_jal;
	assign jump_target = pc_plus_imm;

	// --------------------------------------------------------------------------
	// ID/EX register
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_alu_op   <= alu_add;
			ex_alusrc   <= 1'b0;
			ex_memread  <= 1'b0;
			ex_memwrite <= 1'b0;
			ex_memtoreg <= 1'b0;
			ex_regwrite <= 1'b0;
			ex_jal      <= 1'b0;
			ex_branch   <= 1'b0;
			ex_bne      <= 1'b0;
		end else if (!stall) begin
			ex_alu_op   <= bubble ? alu_add : alu_op;
			ex_alusrc   <= alusrc & ~bubble;
			ex_memread  <= memread & ~bubble;
			ex_memwrite <= memwrite & ~bubble;
			ex_memtoreg <= memtoreg & ~bubble;
			ex_regwrite <= regwrite & ~bubble;
			ex_jal      <= is_jal & ~bubble;
			ex_branch   <= is_branch & ~bubble;
			ex_bne      <= id_instr.rfmt.funct3[0] & ~bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_rs1_data      <= pick(fwd_a, rf_a, mem_fwd_data, ex_result, wb_data);
			ex_rs2_data      <= pick(fwd_b, rf_b, mem_fwd_data, ex_result, wb_data);
			ex_imm           <= imm;
			ex_rd            <= id_instr.rfmt.rd;
			ex_pc_plus4      <= id_pc + pc_width'(4);
			ex_branch_target <= pc_plus_imm;
		end
	end

endmodule

/* logic/rv_fetch.sv */
// program counter, next-PC choice and IF/ID register
`timescale 1ns/1ps

module rv_fetch
	import rv_pipe_pkg::*;
#(
	parameter int pc_width = 9
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	input  logic                pc_hold,
	input  logic                flush_if,
	input  logic                jump_taken,
	input  logic [pc_width-1:0] jump_target,
	input  logic                branch_taken,
	input  logic [pc_width-1:0] branch_target,
	output logic [pc_width-3:0] imem_addr,
	input  logic [xlen-1:0]     imem_rdata,
	output instr_t              id_instr,
	output logic [pc_width-1:0] id_pc
);

	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] pc_next;

	assign imem_addr = pc[pc_width-1:2];

	// branch in EX is older than a jal in ID, so it wins
	always_comb begin
		if (branch_taken)
			pc_next = branch_target;
		else if (jump_taken)
			pc_next = jump_target;
		else if (pc_hold)
			pc_next = pc;
		else
			pc_next = pc + pc_width'(4);
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= '0;
		else if (!stall)
			pc <= pc_next;
	end

	// IF/ID, a cleared word decodes as a nop
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_instr <= '0;
		end else if (!stall) begin
			if (flush_if)
				id_instr <= '0;
			else if (!pc_hold)
				id_instr <= imem_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && !pc_hold)
			id_pc <= pc;
	end

endmodule

/* logic/rv_pipe_pkg.sv */
// widths, opcodes, ALU codes, forwarding codes and the instruction union
package rv_pipe_pkg;

	localparam int xlen           = 32;
	localparam int reg_addr_width = 5;

	// --------------------------------------------------------------------------
	// opcodes of the supported subset
	// --------------------------------------------------------------------------
	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_slt = 4'd4
	} alu_op_t;

	// operand source in decode, nearest producer first
	localparam logic [1:0] fwd_rf  = 2'b00;
	localparam logic [1:0] fwd_mem = 2'b01;
	localparam logic [1:0] fwd_ex  = 2'b10;
	localparam logic [1:0] fwd_wb  = 2'b11;

	// --------------------------------------------------------------------------
	// one word, read as register format or as store/branch format
	// --------------------------------------------------------------------------
	typedef union packed {
		struct packed {
			logic [6:0]                funct7;
			logic [reg_addr_width-1:0] rs2;
			logic [reg_addr_width-1:0] rs1;
			logic [2:0]                funct3;
			logic [reg_addr_width-1:0] rd;
			logic [6:0]                opcode;
		} rfmt;
		struct packed {
			logic [6:0]                imm_hi;
			logic [reg_addr_width-1:0] rs2;
			logic [reg_addr_width-1:0] rs1;
			logic [2:0]                funct3;
			logic [4:0]                imm_lo;
			logic [6:0]                opcode;
		} sfmt;
	} instr_t;

endpackage
